/* verilog.f */
design/lcd_timing_pkg.sv
design/lcd_cmd_pkg.sv
design/lcd_host_port.sv
design/lcd_init_sequencer.sv
design/lcd_bus_cycle.sv
design/lcd_ctrl_top.sv
test/lcd_panel_model.sv
test/tb_lcd_ctrl.sv

/* Bender.yml */
package:
  name: lcd_ctrl

sources:
  - files:
      - design/lcd_timing_pkg.sv
      - design/lcd_cmd_pkg.sv
      - design/lcd_host_port.sv
      - design/lcd_init_sequencer.sv
      - design/lcd_bus_cycle.sv
      - design/lcd_ctrl_top.sv
  - target: test
    files:
      - test/lcd_panel_model.sv
      - test/tb_lcd_ctrl.sv

/* test/tb_lcd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_ctrl;

	localparam int WORD_W = lcd_cmd_pkg::WORD_W;
	localparam int CFG_W = lcd_cmd_pkg::CFG_W;
	localparam int CNT_W = lcd_timing_pkg::CNT_W;
	localparam int N_INIT = lcd_cmd_pkg::N_INIT;
	localparam int N_HOST = 40;
	localparam int N_TOTAL = N_INIT + N_HOST;
	localparam int MAX_IDLE = 250;	// worst idle gap between requests
	localparam int US = lcd_timing_pkg::CLK_PER_US;
	localparam int FIRST_RISE =
		(lcd_timing_pkg::T_POWER_US + lcd_timing_pkg::T_SETUP_US) * US + 1;
	localparam int E_HIGH = lcd_timing_pkg::T_E_HIGH_US * US;
	localparam int CYCLE = lcd_timing_pkg::T_CYCLE_US * US;
	localparam int CLEAR_EXTRA = lcd_timing_pkg::T_CLEAR_EXTRA_US * US;
	localparam int ENTRY_EXTRA = lcd_timing_pkg::T_ENTRY_EXTRA_US * US;
	localparam int INIT_TIME = lcd_timing_pkg::T_POWER_US * US + N_INIT * CYCLE +
		CLEAR_EXTRA + ENTRY_EXTRA;
	localparam int TIMEOUT = 2 * (INIT_TIME + N_HOST * (CYCLE + MAX_IDLE));

	logic clk;
	logic rst;
	logic [CFG_W-1:0] cfg;
	logic req;
	logic [WORD_W-1:0] word;
	logic ack;
	logic busy;
	logic e;
	logic rs;
	logic rw;
	logic [lcd_cmd_pkg::DATA_W-1:0] data;

	logic cap_valid;
	logic [WORD_W-1:0] cap_word;
	logic [CNT_W-1:0] cap_high;
	logic [CNT_W-1:0] cap_gap;

	logic [WORD_W-1:0] exp_q[$];	// words in the order the panel must see them
	int since_rst;	// cycles since rst fell
	int run_cycles;
	int captured;
	bit e_seen;
	logic ack_q;
	logic req_q;

	lcd_ctrl_top i_dut (
		.clk (clk),
		.rst (rst),
		.cfg (cfg),
		.req (req),
		.word (word),
		.ack (ack),
		.busy (busy),
		.e (e),
		.rs (rs),
		.rw (rw),
		.data (data)
	);

	lcd_panel_model i_panel (
		.clk (clk),
		.rst (rst),
		.e (e),
		.rs (rs),
		.rw (rw),
		.data (data),
		.cap_valid (cap_valid),
		.cap_word (cap_word),
		.cap_high (cap_high),
		.cap_gap (cap_gap)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_cycles(input string name, input logic [CNT_W-1:0] got,
			input logic [CNT_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_spacing(input string name, input logic [CNT_W-1:0] got,
			input logic [CNT_W-1:0] min);
		if (got < min)
			abort_run($sformatf("[ERROR] %s got 0x%h expected at least 0x%h",
				name, got, min));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// hd44780 instruction encodings, rs and rw low
	function automatic logic [WORD_W-1:0] init_instruction(input int n,
			input logic [CFG_W-1:0] c);
		logic [7:0] d;
		case (n)
			0: begin
				d = 8'h30;	// function set, 8-bit bus
				d[3] = c[lcd_cmd_pkg::CFG_LINES];
				d[2] = c[lcd_cmd_pkg::CFG_FONT];
			end
			1: begin
				d = 8'h08;
				d[2] = c[lcd_cmd_pkg::CFG_DISP];
				d[1] = c[lcd_cmd_pkg::CFG_CURSOR];
				d[0] = c[lcd_cmd_pkg::CFG_BLINK];
			end
			2: d = 8'h01;	// clear
			default: begin
				d = 8'h04;	// entry mode
				d[1] = c[lcd_cmd_pkg::CFG_INC];
				d[0] = c[lcd_cmd_pkg::CFG_SHIFT];
			end
		endcase
		return {2'b00, d};
	endfunction

	// extra wait added to the spacing before word n
	function automatic int extra_before(input int n);
		if (n == 3)
			return CLEAR_EXTRA;	// clear is word 2
		else if (n == 4)
			return ENTRY_EXTRA;
		else
			return 0;
	endfunction

	task automatic send_word(input logic [WORD_W-1:0] w);
		word = w;
		req = 1'b1;
		do @(negedge clk); while (!ack);
		exp_q.push_back(w);	// handed over
		req = 1'b0;
		do @(negedge clk); while (ack);
	endtask

	always @(posedge clk) begin
		if (rst)
			since_rst <= 0;
		else
			since_rst <= since_rst + 1;
	end

	// ack may only answer a request
	always @(posedge clk) begin
		ack_q <= ack;
		req_q <= req;
		if (!rst && ack && !ack_q && !req_q)
			abort_run("ack rose while req was low");
	end

	always @(posedge clk) begin
		run_cycles++;
		if (run_cycles > TIMEOUT)
			abort_run("timeout, the controller did not finish all words");
	end

	always @(negedge clk) begin
		if (since_rst != 0) begin
			if (e && !e_seen) begin
				e_seen = 1'b1;
				check_cycles("first e rise", CNT_W'(since_rst), CNT_W'(FIRST_RISE));
			end
			if (captured < N_INIT)
				check_bit("busy", busy, 1'b1);	// init still running
			if (cap_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("panel captured a word that was never sent");
				end else begin
					check_word("bus word", cap_word, exp_q.pop_front());
					check_cycles("e high time", cap_high, CNT_W'(E_HIGH));
					if (captured > 0)
						check_spacing("e rise spacing", cap_gap,
							CNT_W'(CYCLE + extra_before(captured)));
					captured++;
				end
			end
		end
	end

	initial begin
		logic [WORD_W-1:0] w;
		int gap;
		rst = 1'b1;
		req = 1'b0;
		word = '0;
		cfg = '0;
		void'($urandom(32'h3b54_4221));
		cfg = CFG_W'($urandom);
		for (int n = 0; n < N_INIT; n++)
			exp_q.push_back(init_instruction(n, cfg));

		repeat (10) @(negedge clk);
		check_bit("e", e, 1'b0);
		check_word("{rs,rw,data}", {rs, rw, data}, '0);
		check_bit("ack", ack, 1'b0);
		check_bit("busy", busy, 1'b1);
		rst = 1'b0;

		for (int i = 0; i < N_HOST; i++) begin
			w = {1'($urandom), 1'b0, 8'($urandom)};	// rw stays 0
			send_word(w);
			if ($urandom_range(3) == 0)
				gap = $urandom_range(MAX_IDLE);
			else
				gap = $urandom_range(2);	// mostly back to back
			repeat (gap) @(negedge clk);
		end

		wait (captured == N_TOTAL);
		while (busy)
			@(negedge clk);	// last hold-off still running
		@(negedge clk);
		check_bit("busy", busy, 1'b0);
		if (captured == N_TOTAL && exp_q.size() == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			abort_run("word count on the panel does not match the words sent");
		end
	end

endmodule

`default_nettype wire

/* test/lcd_panel_model.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_panel_model (
	input logic clk,
	input logic rst,

	// panel pins
	input logic e,
	input logic rs,
	input logic rw,
	input logic [lcd_cmd_pkg::DATA_W-1:0] data,

	// one report per falling e
	output logic cap_valid,
	output logic [lcd_cmd_pkg::WORD_W-1:0] cap_word,
	output logic [lcd_timing_pkg::CNT_W-1:0] cap_high,	// e high time in cycles
	output logic [lcd_timing_pkg::CNT_W-1:0] cap_gap	// rise to previous rise
);

	localparam int CW = lcd_timing_pkg::CNT_W;

	logic e_q;
	logic [CW-1:0] high_cnt;
	logic [CW-1:0] since_rise;	// saturates, long host idles only
	logic [CW-1:0] gap_at_rise;

	always_ff @(posedge clk) begin
		if (rst) begin
			cap_valid <= 1'b0;
			cap_word <= '0;
			cap_high <= '0;
			cap_gap <= '0;
			e_q <= 1'b0;
			high_cnt <= '0;
			since_rise <= '0;
			gap_at_rise <= '0;
		end else begin
			cap_valid <= 1'b0;
			e_q <= e;
			if (since_rise != '1)
				since_rise <= since_rise + 1'b1;
			if (e && !e_q) begin
				gap_at_rise <= since_rise;
				since_rise <= CW'(1);
				high_cnt <= CW'(1);
			end else if (e) begin
				high_cnt <= high_cnt + 1'b1;
			end
			// the panel latches the bus on falling e
			if (!e && e_q) begin
				cap_valid <= 1'b1;
				cap_word <= {rs, rw, data};
				cap_high <= high_cnt;
				cap_gap <= gap_at_rise;
			end
		end
	end

endmodule

`default_nettype wire

/* design/lcd_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_top (
	input logic clk,
	input logic rst,

	input logic [lcd_cmd_pkg::CFG_W-1:0] cfg,	// panel options for init

	// host port
	input logic req,
	input logic [lcd_cmd_pkg::WORD_W-1:0] word,
	output logic ack,
	output logic busy,

	// panel pins
	output logic e,
	output logic rs,
	output logic rw,
	output logic [lcd_cmd_pkg::DATA_W-1:0] data
);

	logic hold_valid;
	logic hold_take;
	logic [lcd_cmd_pkg::WORD_W-1:0] hold_word;

	logic start;
	logic cyc_busy;
	logic [lcd_cmd_pkg::WORD_W-1:0] cyc_word;
	logic [lcd_timing_pkg::CNT_W-1:0] cyc_extra;

	lcd_host_port i_host_port (
		.clk (clk),
		.rst (rst),
		.req (req),
		.word (word),
		.ack (ack),
		.hold_take (hold_take),
		.hold_valid (hold_valid),
		.hold_word (hold_word)
	);

	lcd_init_sequencer i_init_seq (
		.clk (clk),
		.rst (rst),
		.cfg (cfg),
		.hold_valid (hold_valid),
		.hold_word (hold_word),
		.hold_take (hold_take),
		.cyc_busy (cyc_busy),
		.start (start),
		.cyc_word (cyc_word),
		.cyc_extra (cyc_extra),
		.busy (busy)
	);

	lcd_bus_cycle i_bus_cycle (
		.clk (clk),
		.rst (rst),
		.start (start),
		.cyc_word (cyc_word),
		.cyc_extra (cyc_extra),
		.cyc_busy (cyc_busy),
		.e (e),
		.rs (rs),
		.rw (rw),
		.data (data)
	);

endmodule

`default_nettype wire

/* design/lcd_bus_cycle.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_cycle (
	input logic clk,
	input logic rst,

	input logic start,
	input logic [lcd_cmd_pkg::WORD_W-1:0] cyc_word,
	input logic [lcd_timing_pkg::CNT_W-1:0] cyc_extra,
	output logic cyc_busy,

	// panel pins
	output logic e,
	output logic rs,
	output logic rw,
	output logic [lcd_cmd_pkg::DATA_W-1:0] data
);

	logic [lcd_timing_pkg::CNT_W-1:0] cnt;	// 0 in the first valid cycle
	logic [lcd_timing_pkg::CNT_W-1:0] end_cnt;	// last count of this cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			cyc_busy <= 1'b0;
			cnt <= '0;
			rs <= 1'b0;
			rw <= 1'b0;
			data <= '0;
		end else if (start) begin
			cyc_busy <= 1'b1;
			cnt <= '0;
			rs <= cyc_word[lcd_cmd_pkg::WORD_RS];
			rw <= cyc_word[lcd_cmd_pkg::WORD_RW];
			data <= cyc_word[lcd_cmd_pkg::DATA_W-1:0];	// held until next start
		end else if (cyc_busy) begin
			cnt <= cnt + 1'b1;
			if (cnt == end_cnt)
				cyc_busy <= 1'b0;	// hold-off done
		end
	end

	// standard cycle plus whatever the instruction needs on top
	always_ff @(posedge clk) begin
		if (start)
			end_cnt <= lcd_timing_pkg::CYCLE_END + cyc_extra;
	end

	// setup, then high phase, low phase runs to end of cycle
	assign e = (cnt >= lcd_timing_pkg::E_RISE) && (cnt < lcd_timing_pkg::E_FALL);

	e_inside_cycle: assert property (
		@(posedge clk) disable iff (rst)
		e |-> cyc_busy
	);

	// the panel latches on falling e, so the bus may not move under it
	bus_stable_under_e: assert property (
		@(posedge clk) disable iff (rst)
		(e && $past(e)) |-> $stable({rs, rw, data})
	);

endmodule

`default_nettype wire

/* design/lcd_init_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_init_sequencer (
	input logic clk,
	input logic rst,

	input logic [lcd_cmd_pkg::CFG_W-1:0] cfg,

	// holding register of the host port
	input logic hold_valid,
	input logic [lcd_cmd_pkg::WORD_W-1:0] hold_word,
	output logic hold_take,

	// bus cycle engine
	input logic cyc_busy,
	output logic start,
	output logic [lcd_cmd_pkg::WORD_W-1:0] cyc_word,
	output logic [lcd_timing_pkg::CNT_W-1:0] cyc_extra,

	output logic busy
);

	// fsm as two flags: power-up wait, init issue, run
	logic powered;	// power-up wait over
	logic running;	// init list issued, host words pass through

	logic [lcd_timing_pkg::CNT_W-1:0] pwr_cnt;
	logic [lcd_cmd_pkg::IDX_W-1:0] idx;	// next init instruction

	logic [lcd_cmd_pkg::DATA_W-1:0] init_data;
	logic [lcd_timing_pkg::CNT_W-1:0] init_extra;
	logic init_issue;

	// instruction bytes built from the opcodes and the live config word
	always_comb begin
		init_data = lcd_cmd_pkg::OP_CLEAR;
		init_extra = '0;
		case (idx)
			lcd_cmd_pkg::IDX_FUNC_SET: begin
				init_data = {lcd_cmd_pkg::OP_FUNC_SET,
					cfg[lcd_cmd_pkg::CFG_LINES],
					cfg[lcd_cmd_pkg::CFG_FONT],
					2'b00};
			end
			lcd_cmd_pkg::IDX_DISP_CTRL: begin
				init_data = {lcd_cmd_pkg::OP_DISP_CTRL,
					cfg[lcd_cmd_pkg::CFG_DISP],
					cfg[lcd_cmd_pkg::CFG_CURSOR],
					cfg[lcd_cmd_pkg::CFG_BLINK]};
			end
			lcd_cmd_pkg::IDX_CLEAR: begin
				init_data = lcd_cmd_pkg::OP_CLEAR;
				init_extra = lcd_timing_pkg::CLEAR_EXTRA;	// clear is slow
			end
			lcd_cmd_pkg::IDX_ENTRY: begin
				init_data = {lcd_cmd_pkg::OP_ENTRY,
					cfg[lcd_cmd_pkg::CFG_INC],
					cfg[lcd_cmd_pkg::CFG_SHIFT]};
				init_extra = lcd_timing_pkg::ENTRY_EXTRA;
			end
			default: begin
				init_data = lcd_cmd_pkg::OP_CLEAR;
				init_extra = '0;
			end
		endcase
	end

	assign init_issue = powered && !running && !cyc_busy;
	assign hold_take = running && !cyc_busy && hold_valid;	// take and start together
	assign start = init_issue || hold_take;

	// init words go out with rs and rw low
	assign cyc_word = running ? hold_word : {2'b00, init_data};
	assign cyc_extra = running ? '0 : init_extra;

	assign busy = !running || cyc_busy || hold_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			powered <= 1'b0;
			running <= 1'b0;
			pwr_cnt <= '0;
			idx <= '0;
		end else if (!powered) begin
			if (pwr_cnt == lcd_timing_pkg::PWR_LAST)
				powered <= 1'b1;
			else
				pwr_cnt <= pwr_cnt + 1'b1;
		end else if (init_issue) begin
			idx <= idx + 1'b1;
			if (idx == lcd_cmd_pkg::INIT_LAST)
				running <= 1'b1;	// last init word is on its way
		end
	end

	// a start is always picked up by an idle engine
	start_when_idle: assert property (
		@(posedge clk) disable iff (rst)
		start |-> !cyc_busy ##1 cyc_busy
	);

endmodule

`default_nettype wire

/* design/lcd_host_port.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_host_port (
	input logic clk,
	input logic rst,

	// host side, four-phase req/ack
	input logic req,
	input logic [lcd_cmd_pkg::WORD_W-1:0] word,
	output logic ack,

	// towards the sequencer
	input logic hold_take,
	output logic hold_valid,
	output logic [lcd_cmd_pkg::WORD_W-1:0] hold_word
);

	logic latch;	// accept the host word this cycle

	// ack low is the wait-for-req phase, ack high the wait-for-release phase.
	// a full holding register keeps ack low, which stalls the host
	assign latch = !ack && req && !hold_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			if (latch) begin
				ack <= 1'b1;
				hold_valid <= 1'b1;
			end else begin
				if (ack && !req)
					ack <= 1'b0;	// host released, close the handshake
				if (hold_take)
					hold_valid <= 1'b0;	// word moved to the bus engine
			end
		end
	end

	always_ff @(posedge clk) begin
		if (latch)
			hold_word <= word;
	end

	// the sequencer only takes what is actually held
	take_needs_valid: assert property (
		@(posedge clk) disable iff (rst)
		hold_take |-> hold_valid
	);

	// ack answers a request seen in the cycle before
	ack_follows_req: assert property (
		@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req)
	);

endmodule

`default_nettype wire

/* design/lcd_cmd_pkg.sv */
`default_nettype none

package lcd_cmd_pkg;

	// config word, msb first: lines, font, display, cursor, blink, inc, shift
	localparam int CFG_W = 7;
	localparam int CFG_LINES = 6;
	localparam int CFG_FONT = 5;
	localparam int CFG_DISP = 4;
	localparam int CFG_CURSOR = 3;
	localparam int CFG_BLINK = 2;
	localparam int CFG_INC = 1;
	localparam int CFG_SHIFT = 0;

	// bus word is {rs, rw, data}
	localparam int DATA_W = 8;
	localparam int WORD_W = 10;
	localparam int WORD_RS = 9;
	localparam int WORD_RW = 8;

	// fixed upper bits of the init instructions, option bits fill the rest
	localparam logic [3:0] OP_FUNC_SET = 4'b0011;	// 8-bit interface
	localparam logic [4:0] OP_DISP_CTRL = 5'b00001;
	localparam logic [7:0] OP_CLEAR = 8'b0000_0001;	// no option bits
	localparam logic [5:0] OP_ENTRY = 6'b000001;

	// init list bookkeeping
	localparam int N_INIT = 4;
	localparam int IDX_W = 2;
	localparam logic [IDX_W-1:0] IDX_FUNC_SET = 2'd0;
	localparam logic [IDX_W-1:0] IDX_DISP_CTRL = 2'd1;
	localparam logic [IDX_W-1:0] IDX_CLEAR = 2'd2;
	localparam logic [IDX_W-1:0] IDX_ENTRY = 2'd3;
	localparam logic [IDX_W-1:0] INIT_LAST = IDX_W'(N_INIT - 1);

endpackage

`default_nettype wire

/* design/lcd_timing_pkg.sv */
`default_nettype none

package lcd_timing_pkg;

	// base time unit is one microsecond
	localparam int CLK_PER_US = 3;	// clock cycles per us

	localparam int CNT_W = 11;	// wide enough for the power-up count

	// all waits in us
	localparam int T_POWER_US = 500;	// panel power-up
	localparam int T_SETUP_US = 1;	// word valid to e rise
	localparam int T_E_HIGH_US = 13;	// enable pulse width
	localparam int T_CYCLE_US = 50;	// word valid to next word allowed
	localparam int T_CLEAR_EXTRA_US = 150;	// clear needs 200 in all
	localparam int T_ENTRY_EXTRA_US = 50;	// entry mode needs 100 in all

	// derived counts in clock cycles, sized for the wait counters
	localparam logic [CNT_W-1:0] PWR_LAST = CNT_W'(T_POWER_US * CLK_PER_US - 1);
	localparam logic [CNT_W-1:0] E_RISE = CNT_W'(T_SETUP_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] E_FALL =
		CNT_W'((T_SETUP_US + T_E_HIGH_US) * CLK_PER_US);

	// the cycle counter starts one clock after start, and busy drops one
	// clock after the last count, hence the two
	localparam logic [CNT_W-1:0] CYCLE_END = CNT_W'(T_CYCLE_US * CLK_PER_US - 2);

	localparam logic [CNT_W-1:0] CLEAR_EXTRA = CNT_W'(T_CLEAR_EXTRA_US * CLK_PER_US);
	localparam logic [CNT_W-1:0] ENTRY_EXTRA = CNT_W'(T_ENTRY_EXTRA_US * CLK_PER_US);

endpackage

`default_nettype wire
